// File: Makefile
SOURCES := $(shell grep -v '^+' compile.f)

.PHONY: all run clean

all: obj_dir/Vpanel_input_tb

obj_dir/Vpanel_input_tb: compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module panel_input_tb \
		-f compile.f -o Vpanel_input_tb

run: obj_dir/Vpanel_input_tb
	./obj_dir/Vpanel_input_tb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/panel_pkg.sv
`default_nettype none

package panel_pkg;

	// default sizes handed down from the top level parameters
	localparam int default_num_buttons = 4;

	// two flops are the usual minimum against metastability
	localparam int default_sync_depth = 2;

	// cycles a new level has to hold before the debouncer accepts it
	localparam int default_debounce_cycles = 20;

	// free-running timestamp width, wraps silently
	localparam int time_width = 16;

	// per-button press counters wrap at this width
	localparam int count_width = 8;

	// button number on the event stream, room for up to 256 buttons
	typedef logic [7:0] button_index_t;

	// one record on the event stream, 25 bits in all
	// pressed is the debounced level at the time the record is built
	// stamp is the timestamp counter in the cycle event_valid is high
	typedef struct packed {
		button_index_t button;
		logic pressed;
		logic [time_width-1:0] stamp;
	} panel_event_t;

endpackage

`default_nettype wire

// File: compile.f
common/panel_pkg.sv
source/input_synchronizer.sv
debounce/button_debounce.sv
source/panel_control.sv
source/press_counter.sv
source/panel_input_top.sv
test/panel_input_tb.sv

// File: debounce/button_debounce.sv
`timescale 1ns/100ps
`default_nettype none

module button_debounce #(
	parameter int NUM_BUTTONS = panel_pkg::default_num_buttons,
	parameter int DEBOUNCE_CYCLES = panel_pkg::default_debounce_cycles
) (
	input logic clock,
	input logic randy,
	input logic [NUM_BUTTONS-1:0] button_sync,
	output logic [NUM_BUTTONS-1:0] button_level,
	output logic [NUM_BUTTONS-1:0] button_changed
);

	// wide enough to hold DEBOUNCE_CYCLES - 1
	localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

	// the flip happens on the last of DEBOUNCE_CYCLES differing samples
	localparam logic [CW-1:0] LAST_COUNT = CW'(DEBOUNCE_CYCLES - 1);

	genvar i;

	for (i = 0; i < NUM_BUTTONS; i++) begin : g_button

		// consecutive cycles the input has disagreed with the accepted level
		logic [CW-1:0] diff_count;

		always_ff @(posedge clock or posedge randy) begin
			if (randy) begin
				diff_count <= '0;
				button_level[i] <= 1'b0;
				button_changed[i] <= 1'b0;
			end else begin
				button_changed[i] <= 1'b0;
				if (button_sync[i] == button_level[i]) begin
					// any agreeing sample throws away the run so far
					diff_count <= '0;
				end else if (diff_count == LAST_COUNT) begin
					diff_count <= '0;
					button_level[i] <= button_sync[i];
					button_changed[i] <= 1'b1;
				end else begin
					diff_count <= diff_count + 1'b1;
				end
			end
		end

	end

	// a strobe shows up exactly on the buttons whose level just flipped
	assert property (@(posedge clock) disable iff (randy)
		(button_level ^ $past(button_level)) == button_changed)
	else $error("button_debounce: change strobe out of step with level");

endmodule

`default_nettype wire

// File: source/input_synchronizer.sv
`timescale 1ns/100ps
`default_nettype none

module input_synchronizer #(
	parameter int NUM_BUTTONS = panel_pkg::default_num_buttons,
	parameter int SYNC_DEPTH = panel_pkg::default_sync_depth
) (
	input logic clock,
	input logic randy,
	input logic [NUM_BUTTONS-1:0] async_levels,
	output logic [NUM_BUTTONS-1:0] sync_levels
);

	// stage 0 takes the raw pins, the last stage is safe to use
	logic [SYNC_DEPTH-1:0][NUM_BUTTONS-1:0] stage;

	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			stage <= '0;
		end else begin
			stage <= {stage[SYNC_DEPTH-2:0], async_levels};
		end
	end

	assign sync_levels = stage[SYNC_DEPTH-1];

	// a single flop gives no settling time at all
	initial begin
		assert (SYNC_DEPTH >= 2)
		else $fatal(1, "input_synchronizer needs SYNC_DEPTH of at least 2");
	end

endmodule

`default_nettype wire

// File: source/panel_control.sv
`timescale 1ns/100ps
`default_nettype none

module panel_control #(
	parameter int NUM_BUTTONS = panel_pkg::default_num_buttons
) (
	input logic clock,
	input logic randy,
	input logic [NUM_BUTTONS-1:0] button_level,
	input logic [NUM_BUTTONS-1:0] button_changed,
	output logic event_valid,
	output panel_pkg::panel_event_t event_data
);

	import panel_pkg::*;

	// buttons with a change not yet sent out
	logic [NUM_BUTTONS-1:0] pending;

	// includes this cycle's strobes so a lone change goes out next cycle
	logic [NUM_BUTTONS-1:0] pending_now;
	logic [NUM_BUTTONS-1:0] grant;
	logic any_pending;
	button_index_t grant_index;
	logic [time_width-1:0] timestamp;

	assign pending_now = pending | button_changed;
	assign any_pending = |pending_now;

	// lowest set bit wins
	assign grant = pending_now & (~pending_now + 1'b1);

	always_comb begin
		grant_index = '0;
		for (int i = 0; i < NUM_BUTTONS; i++) begin
			if (grant[i]) begin
				grant_index = button_index_t'(i);
			end
		end
	end

	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			timestamp <= '0;
		end else begin
			timestamp <= timestamp + 1'b1;
		end
	end

	// a repeat change while pending just stays pending and the level is read at emit time
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			pending <= '0;
		end else begin
			pending <= pending_now & ~grant;
		end
	end

	// the record only loads on an emit so it holds the last stamp between events
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			event_valid <= 1'b0;
			event_data <= '0;
		end else begin
			event_valid <= any_pending;
			if (any_pending) begin
				event_data.button <= grant_index;
				event_data.pressed <= |(button_level & grant);
				// equals the counter in the cycle event_valid is high
				event_data.stamp <= timestamp + 1'b1;
			end
		end
	end

	// every record belongs to a button that had a change waiting
	assert property (@(posedge clock) disable iff (randy)
		event_valid |->
		($past(pending_now) & (NUM_BUTTONS'(1) << event_data.button)) != '0)
	else $error("panel_control: event for a button that was not pending");

	// consecutive event stamps never repeat
	assert property (@(posedge clock) disable iff (randy)
		event_valid |-> event_data.stamp != $past(event_data.stamp))
	else $error("panel_control: event stamp repeated");

endmodule

`default_nettype wire

// File: source/panel_input_top.sv
`timescale 1ns/100ps
`default_nettype none

module panel_input_top #(
	parameter int NUM_BUTTONS = panel_pkg::default_num_buttons,
	parameter int SYNC_DEPTH = panel_pkg::default_sync_depth,
	parameter int DEBOUNCE_CYCLES = panel_pkg::default_debounce_cycles
) (
	input logic clock,
	input logic randy,
	input logic [NUM_BUTTONS-1:0] button_raw,
	output logic event_valid,
	output panel_pkg::panel_event_t event_data,
	input panel_pkg::button_index_t count_select,
	output logic [panel_pkg::count_width-1:0] press_count
);

	logic [NUM_BUTTONS-1:0] button_sync;
	logic [NUM_BUTTONS-1:0] button_level;
	logic [NUM_BUTTONS-1:0] button_changed;

	input_synchronizer #(
		.NUM_BUTTONS(NUM_BUTTONS),
		.SYNC_DEPTH(SYNC_DEPTH)
	) sync_stage (
		.clock(clock),
		.randy(randy),
		.async_levels(button_raw),
		.sync_levels(button_sync)
	);

	button_debounce #(
		.NUM_BUTTONS(NUM_BUTTONS),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) debounce_bank (
		.clock(clock),
		.randy(randy),
		.button_sync(button_sync),
		.button_level(button_level),
		.button_changed(button_changed)
	);

	// turns debounced changes into the serial event stream
	panel_control #(
		.NUM_BUTTONS(NUM_BUTTONS)
	) control (
		.clock(clock),
		.randy(randy),
		.button_level(button_level),
		.button_changed(button_changed),
		.event_valid(event_valid),
		.event_data(event_data)
	);

	// counts presses straight off the outgoing stream
	press_counter #(
		.NUM_BUTTONS(NUM_BUTTONS)
	) counter_bank (
		.clock(clock),
		.randy(randy),
		.event_valid(event_valid),
		.event_data(event_data),
		.count_select(count_select),
		.press_count(press_count)
	);

endmodule

`default_nettype wire

// File: source/press_counter.sv
`timescale 1ns/100ps
`default_nettype none

module press_counter #(
	parameter int NUM_BUTTONS = panel_pkg::default_num_buttons
) (
	input logic clock,
	input logic randy,
	input logic event_valid,
	input panel_pkg::panel_event_t event_data,
	input panel_pkg::button_index_t count_select,
	output logic [panel_pkg::count_width-1:0] press_count
);

	import panel_pkg::*;

	logic [NUM_BUTTONS-1:0][count_width-1:0] counts;
	logic count_enable;

	// releases never count
	assign count_enable = event_valid & event_data.pressed;

	// an out-of-range button matches no counter and is dropped
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			counts <= '0;
		end else begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				if (count_enable && (event_data.button == button_index_t'(i))) begin
					counts[i] <= counts[i] + 1'b1;
				end
			end
		end
	end

	// read port, an unknown button reads zero
	always_comb begin
		press_count = '0;
		for (int i = 0; i < NUM_BUTTONS; i++) begin
			if (count_select == button_index_t'(i)) begin
				press_count = counts[i];
			end
		end
	end

	// the event source should never name a button beyond the bank
	assert property (@(posedge clock) disable iff (randy)
		event_valid |-> event_data.button < NUM_BUTTONS)
	else $error("press_counter: event for button %0d out of range", event_data.button);

endmodule

`default_nettype wire

// File: test/panel_input_tb.sv
`timescale 1ns/100ps
`default_nettype none

module panel_input_tb;

	import panel_pkg::*;

	localparam int NB = default_num_buttons;
	localparam int SYNC = default_sync_depth;
	localparam int DEB = default_debounce_cycles;

	// pin to strobe with the worst arbitration delay plus slack
	localparam int SETTLE = SYNC + DEB + NB + 10;
	localparam int HOLD = 2 * DEB;
	localparam int SCENARIOS = 5;
	localparam int STEPS = 24;
	localparam int TIMEOUT_CYCLES = SCENARIOS * STEPS * (SETTLE + HOLD) * 2;

	// longest excursion that must still be thrown away
	localparam int GLITCH_MAX = DEB - SYNC - 1;

	logic clock;
	logic randy;
	logic [NB-1:0] button_raw;
	logic event_valid;
	panel_event_t event_data;
	button_index_t count_select;
	logic [count_width-1:0] press_count;

	// reference model of the panel
	logic [NB-1:0] model_level;
	int model_presses [NB];
	int expected_events [NB];
	int expected_total;
	logic [time_width-1:0] model_time;

	// what the DUT has reported so far
	logic [NB-1:0] last_reported;
	int events_seen [NB];
	int event_total;
	logic [time_width-1:0] last_stamp;
	logic have_stamp;

	// read port check driven together with count_select
	logic check_count;
	logic [count_width-1:0] expect_count;

	logic expected_pressed;
	logic previous_pressed;

	string test_name = "reset";
	int value_errors = 0;
	int protocol_errors = 0;
	int cycle_count = 0;

	panel_input_top #(
		.NUM_BUTTONS(NB),
		.SYNC_DEPTH(SYNC),
		.DEBOUNCE_CYCLES(DEB)
	) dut0 (
		.clock(clock),
		.randy(randy),
		.button_raw(button_raw),
		.event_valid(event_valid),
		.event_data(event_data),
		.count_select(count_select),
		.press_count(press_count)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	assign expected_pressed = model_level[event_data.button];
	assign previous_pressed = last_reported[event_data.button];

	// free-running time base that starts from zero when reset lets go
	always @(posedge clock) begin
		if (randy) begin
			model_time <= '0;
		end else begin
			model_time <= model_time + 1'b1;
		end
	end

	always @(posedge clock) begin
		if (randy) begin
			last_reported <= '0;
			event_total <= 0;
			last_stamp <= '0;
			have_stamp <= 1'b0;
			for (int i = 0; i < NB; i++) begin
				events_seen[i] <= 0;
			end
		end else if (event_valid) begin
			last_reported[event_data.button] <= event_data.pressed;
			events_seen[event_data.button] <= events_seen[event_data.button] + 1;
			event_total <= event_total + 1;
			last_stamp <= event_data.stamp;
			have_stamp <= 1'b1;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run still busy after %0d cycles in %s", TIMEOUT_CYCLES, test_name);
			$display("Test failed");
			$finish;
		end
	end

	assert property (@(posedge clock) randy |-> !event_valid)
	else begin
		protocol_errors++;
		$display("event strobe raised while reset was held");
	end

	assert property (@(posedge clock) randy |-> press_count == '0)
	else begin
		value_errors++;
		$display("FAIL %s: press_count expected 0 actual %0d", test_name, $sampled(press_count));
	end

	assert property (@(posedge clock) disable iff (randy)
		event_valid |-> event_data.pressed == expected_pressed)
	else begin
		value_errors++;
		$display("FAIL %s: pressed of button %0d expected %0b actual %0b", test_name,
			$sampled(event_data.button), $sampled(expected_pressed),
			$sampled(event_data.pressed));
	end

	// a bounce that ends where it started must leave no trace
	assert property (@(posedge clock) disable iff (randy)
		event_valid |-> event_data.pressed != previous_pressed)
	else begin
		protocol_errors++;
		$display("button %0d reported the same level twice in a row in %s",
			$sampled(event_data.button), test_name);
	end

	assert property (@(posedge clock) disable iff (randy)
		event_valid && $past(event_valid) |-> event_data.button > $past(event_data.button))
	else begin
		protocol_errors++;
		$display("back-to-back events not in ascending button order in %s", test_name);
	end

	assert property (@(posedge clock) disable iff (randy)
		event_valid && have_stamp |-> event_data.stamp > last_stamp)
	else begin
		value_errors++;
		$display("FAIL %s: stamp expected above %0d actual %0d", test_name,
			$sampled(last_stamp), $sampled(event_data.stamp));
	end

	// the stamp carries the time base of the strobe cycle
	assert property (@(posedge clock) disable iff (randy)
		event_valid |-> event_data.stamp == model_time)
	else begin
		value_errors++;
		$display("FAIL %s: stamp expected %0d actual %0d", test_name,
			$sampled(model_time), $sampled(event_data.stamp));
	end

	assert property (@(posedge clock) disable iff (randy)
		check_count |-> press_count == expect_count)
	else begin
		value_errors++;
		$display("FAIL %s: press_count of button %0d expected %0d actual %0d", test_name,
			$sampled(count_select), $sampled(expect_count), $sampled(press_count));
	end

	// moves the pins and books every change in the model
	task automatic set_levels(input logic [NB-1:0] next);
		@(posedge clock);
		for (int i = 0; i < NB; i++) begin
			if (next[i] != model_level[i]) begin
				expected_events[i]++;
				expected_total++;
				if (next[i]) begin
					model_presses[i]++;
				end
			end
		end
		button_raw <= next;
		model_level <= next;
	endtask

	task automatic wait_for_events();
		while (event_total != expected_total) begin
			@(posedge clock);
		end
	endtask

	task automatic clean_change(input logic [NB-1:0] next);
		set_levels(next);
		wait_for_events();
		repeat (HOLD) @(posedge clock);
	endtask

	task automatic glitch_pulse(input int b);
		@(posedge clock);
		button_raw <= model_level ^ (NB'(1) << b);
		repeat (GLITCH_MAX) @(posedge clock);
		button_raw <= model_level;
	endtask

	// random chatter that always returns home for a cycle or more
	task automatic bounce_button(input int b);
		int away;
		int home;
		repeat (8) begin
			away = 1 + int'($urandom % GLITCH_MAX);
			home = 1 + int'($urandom % 4);
			@(posedge clock);
			button_raw <= model_level ^ (NB'(1) << b);
			repeat (away) @(posedge clock);
			button_raw <= model_level;
			repeat (home) @(posedge clock);
		end
	endtask

	task automatic burst(input logic [NB-1:0] next);
		int changes;
		changes = $countones(next ^ model_level);
		set_levels(next);
		do begin
			@(posedge clock);
		end while (!event_valid);
		for (int k = 1; k < changes; k++) begin
			@(posedge clock);
			assert (event_valid)
			else begin
				protocol_errors++;
				$display("burst of %0d events broke off after %0d strobes", changes, k);
			end
		end
		wait_for_events();
		repeat (HOLD) @(posedge clock);
	endtask

	task automatic check_event_counts();
		for (int i = 0; i < NB; i++) begin
			assert (events_seen[i] == expected_events[i])
			else begin
				value_errors++;
				$display("FAIL %s: events of button %0d expected %0d actual %0d", test_name,
					i, expected_events[i], events_seen[i]);
			end
		end
	endtask

	task automatic check_counts();
		for (int i = 0; i < NB; i++) begin
			@(posedge clock);
			count_select <= button_index_t'(i);
			expect_count <= model_presses[i][count_width-1:0];
			check_count <= 1'b1;
		end
		@(posedge clock);
		check_count <= 1'b0;
	endtask

	initial begin
		logic [NB-1:0] mask;
		void'($urandom(10));
		randy = 1'b1;
		button_raw = '0;
		count_select = '0;
		check_count = 1'b0;
		expect_count = '0;
		model_level = '0;
		expected_total = 0;
		for (int i = 0; i < NB; i++) begin
			model_presses[i] = 0;
			expected_events[i] = 0;
		end

		// sweep the read port while reset is held
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			count_select <= button_index_t'(i % NB);
		end
		randy <= 1'b0;
		check_counts();

		test_name = "clean";
		for (int b = 0; b < NB; b++) begin
			clean_change(model_level | (NB'(1) << b));
			clean_change(model_level & ~(NB'(1) << b));
		end
		check_event_counts();

		test_name = "glitch";
		for (int b = 0; b < NB; b++) begin
			glitch_pulse(b);
			repeat (HOLD) @(posedge clock);
			bounce_button(b);
			repeat (HOLD) @(posedge clock);
		end
		check_event_counts();

		test_name = "simultaneous";
		burst('1);
		burst('0);
		mask = NB'($urandom) | NB'(3);
		burst(mask);
		burst('0);
		check_event_counts();

		test_name = "press_count";
		repeat (STEPS) begin
			mask = NB'($urandom);
			if (mask == '0) begin
				mask = NB'(1);
			end
			clean_change(mask);
			clean_change('0);
		end
		check_event_counts();
		check_counts();

		repeat (SETTLE) @(posedge clock);
		$display("errors: %0d wrong values, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
